/* source/cnn_pkg.sv */
`default_nettype none

// CNN inference package
// Network dimensions, memory address widths, data types and sequencing enums

package cnn_pkg;

    // ========================================================================
    // Network dimensions
    // ========================================================================
    localparam int IMG_SIZE    = 28;
    localparam int CONV_OUT    = 26;
    localparam int POOL_OUT    = 13;
    localparam int KERNEL      = 3;
    localparam int NUM_FILTERS = 16;
    localparam int NUM_CLASSES = 10;
    localparam int FLAT_LEN    = NUM_FILTERS * POOL_OUT * POOL_OUT;

    // Requantisation of conv outputs
    localparam int QUANT_SHIFT = 8;
    localparam int ACT_MAX     = 127;

    // Feature buffer depths
    localparam int BUF_A_DEPTH = NUM_FILTERS * CONV_OUT * CONV_OUT;
    localparam int BUF_B_DEPTH = FLAT_LEN;

    // ========================================================================
    // Address widths
    // ========================================================================
    localparam int IMG_AW     = 10;
    localparam int CONV_W_AW  = 8;
    localparam int CONV_B_AW  = 4;
    localparam int DENSE_W_AW = 15;
    localparam int DENSE_B_AW = 4;
    localparam int BUF_A_AW   = 14;
    localparam int BUF_B_AW   = 12;

    // Pixels, weights and activations share one format
    typedef logic signed [7:0]  pixel_t;
    typedef logic signed [31:0] acc_t;
    typedef acc_t score_array_t [NUM_CLASSES];

    typedef enum logic [2:0] {IDLE, CONV, POOL, DENSE, FINISH} phase_t;

    // Address of v0, then one read per window element
    typedef enum logic [2:0] {
        PS_ADDR0,
        PS_READ0,
        PS_READ1,
        PS_READ2,
        PS_WRITE
    } pool_step_t;

endpackage

`default_nettype wire

/* source/feature_buf_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Feature buffer port bundle
// Write side for the producing engine, read side for the consuming engine

interface feature_buf_if import cnn_pkg::*; #(
    parameter int AW = BUF_A_AW
) ();

    logic [AW-1:0] wr_addr;
    pixel_t        wr_data;
    logic          wr_en;
    logic [AW-1:0] rd_addr;
    pixel_t        rd_data;

    modport mem (
        input  wr_addr,
        input  wr_data,
        input  wr_en,
        input  rd_addr,
        output rd_data
    );

    modport producer (output wr_addr, output wr_data, output wr_en);

    modport consumer (output rd_addr, input rd_data);

endinterface

`default_nettype wire

/* source/feature_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

// Feature buffer RAM
// Synchronous write port and combinational read port

module feature_buffer import cnn_pkg::*; #(
    parameter int DEPTH = BUF_A_DEPTH
) (
    input wire         clk,
    feature_buf_if.mem bus
);

    pixel_t storage [DEPTH];

    always_ff @(posedge clk) begin
        if (bus.wr_en) begin
            storage[bus.wr_addr] <= bus.wr_data;
        end
    end

    // Read data follows the address in the same cycle
    assign bus.rd_data = storage[bus.rd_addr];

endmodule

`default_nettype wire

/* source/conv_engine.sv */
`timescale 1ns/1ns
`default_nettype none

// Layer-1 convolution engine
// 3x3 MAC over the image per filter, then requantise, clamp and store into buffer A

module conv_engine import cnn_pkg::*; (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    output logic                   done,
    output logic [IMG_AW-1:0]      img_addr,
    input  wire pixel_t            img_data,
    output logic [CONV_W_AW-1:0]   conv_w_addr,
    input  wire pixel_t            conv_w_data,
    output logic [CONV_B_AW-1:0]   conv_b_addr,
    input  wire acc_t              conv_b_data,
    feature_buf_if.producer        fmap
);

    typedef enum logic [2:0] {
        C_IDLE,
        C_BIAS_ADDR,
        C_BIAS_CAP,
        C_PREFETCH,
        C_MAC,
        C_SAVE
    } conv_state_t;

    conv_state_t state;
    logic [3:0]  filt;
    logic [4:0]  row;
    logic [4:0]  col;
    logic [1:0]  kr;
    logic [1:0]  kc;
    logic [1:0]  kr_next;
    logic [1:0]  kc_next;
    logic        last_tap;
    logic        last_out;
    acc_t        acc;
    acc_t        shifted;
    pixel_t      act;

    function automatic logic [IMG_AW-1:0] pix_addr(logic [4:0] r, logic [4:0] c,
                                                    logic [1:0] dr, logic [1:0] dc);
        return IMG_AW'((r + dr) * IMG_SIZE + c + dc);
    endfunction

    function automatic logic [CONV_W_AW-1:0] wgt_addr(logic [3:0] f,
                                                       logic [1:0] dr, logic [1:0] dc);
        return CONV_W_AW'(f * KERNEL * KERNEL + dr * KERNEL + dc);
    endfunction

    // Next tap, row-major over the window
    always_comb begin
        if (kc == 2'(KERNEL - 1)) begin
            kr_next = kr + 2'd1;
            kc_next = 2'd0;
        end else begin
            kr_next = kr;
            kc_next = kc + 2'd1;
        end
    end

    assign last_tap = (kr == 2'(KERNEL - 1)) && (kc == 2'(KERNEL - 1));
    assign last_out = (filt == 4'(NUM_FILTERS - 1)) && (row == 5'(CONV_OUT - 1))
                      && (col == 5'(CONV_OUT - 1));

    // Requantise and clamp to 0..ACT_MAX
    always_comb begin
        shifted = acc >>> QUANT_SHIFT;
        if (shifted < 0) begin
            act = '0;
        end else if (shifted > ACT_MAX) begin
            act = pixel_t'(ACT_MAX);
        end else begin
            act = shifted[7:0];
        end
    end

    // ========================================================================
    // Output walk, 13 cycles per activation
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= C_IDLE;
            done       <= 1'b0;
            fmap.wr_en <= 1'b0;
        end else begin
            done       <= 1'b0;
            fmap.wr_en <= 1'b0;
            case (state)
                C_IDLE: begin
                    if (start) begin
                        filt  <= '0;
                        row   <= '0;
                        col   <= '0;
                        state <= C_BIAS_ADDR;
                    end
                end
                C_BIAS_ADDR: begin
                    conv_b_addr <= filt;
                    state       <= C_BIAS_CAP;
                end
                C_BIAS_CAP: begin
                    acc         <= conv_b_data;
                    kr          <= '0;
                    kc          <= '0;
                    img_addr    <= pix_addr(row, col, 2'd0, 2'd0);
                    conv_w_addr <= wgt_addr(filt, 2'd0, 2'd0);
                    state       <= C_PREFETCH;
                end
                C_PREFETCH: begin
                    state <= C_MAC;
                end
                C_MAC: begin
                    acc <= acc + acc_t'(img_data) * acc_t'(conv_w_data);
                    if (last_tap) begin
                        state <= C_SAVE;
                    end else begin
                        kr          <= kr_next;
                        kc          <= kc_next;
                        img_addr    <= pix_addr(row, col, kr_next, kc_next);
                        conv_w_addr <= wgt_addr(filt, kr_next, kc_next);
                    end
                end
                C_SAVE: begin
                    fmap.wr_addr <= BUF_A_AW'(filt * CONV_OUT * CONV_OUT
                                              + row * CONV_OUT + col);
                    fmap.wr_data <= act;
                    fmap.wr_en   <= 1'b1;
                    if (last_out) begin
                        done  <= 1'b1;
                        state <= C_IDLE;
                    end else begin
                        state <= C_BIAS_ADDR;
                        if (col == 5'(CONV_OUT - 1)) begin
                            col <= '0;
                            if (row == 5'(CONV_OUT - 1)) begin
                                row  <= '0;
                                filt <= filt + 4'd1;
                            end else begin
                                row <= row + 5'd1;
                            end
                        end else begin
                            col <= col + 5'd1;
                        end
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/pool_engine.sv */
`timescale 1ns/1ns
`default_nettype none

// 2x2 max pool engine
// Reads each window from buffer A and writes its maximum to buffer B

module pool_engine import cnn_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             start,
    output logic            done,
    feature_buf_if.consumer src,
    feature_buf_if.producer dst
);

    pool_step_t step;
    logic       busy;
    logic [3:0] filt;
    logic [3:0] row;
    logic [3:0] col;
    logic       last_out;
    logic       src_gt;
    pixel_t     max_val;

    function automatic logic [BUF_A_AW-1:0] win_addr(logic [3:0] f, logic [3:0] r,
                                                      logic [3:0] c, logic dr, logic dc);
        return BUF_A_AW'(f * CONV_OUT * CONV_OUT + (2 * r + dr) * CONV_OUT + 2 * c + dc);
    endfunction

    // Activations are never negative, so compare as unsigned
    assign src_gt   = $unsigned(src.rd_data) > $unsigned(max_val);
    assign last_out = (filt == 4'(NUM_FILTERS - 1)) && (row == 4'(POOL_OUT - 1))
                      && (col == 4'(POOL_OUT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            step      <= PS_ADDR0;
            done      <= 1'b0;
            dst.wr_en <= 1'b0;
        end else begin
            done      <= 1'b0;
            dst.wr_en <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    step <= PS_ADDR0;
                    filt <= '0;
                    row  <= '0;
                    col  <= '0;
                end
            end else begin
                case (step)
                    PS_ADDR0: begin
                        src.rd_addr <= win_addr(filt, row, col, 1'b0, 1'b0);
                        step        <= PS_READ0;
                    end
                    PS_READ0: begin
                        max_val     <= src.rd_data;
                        src.rd_addr <= win_addr(filt, row, col, 1'b0, 1'b1);
                        step        <= PS_READ1;
                    end
                    PS_READ1: begin
                        if (src_gt) begin
                            max_val <= src.rd_data;
                        end
                        src.rd_addr <= win_addr(filt, row, col, 1'b1, 1'b0);
                        step        <= PS_READ2;
                    end
                    PS_READ2: begin
                        if (src_gt) begin
                            max_val <= src.rd_data;
                        end
                        src.rd_addr <= win_addr(filt, row, col, 1'b1, 1'b1);
                        step        <= PS_WRITE;
                    end
                    PS_WRITE: begin
                        dst.wr_addr <= BUF_B_AW'(filt * POOL_OUT * POOL_OUT
                                                 + row * POOL_OUT + col);
                        dst.wr_data <= src_gt ? src.rd_data : max_val;
                        dst.wr_en   <= 1'b1;
                        step        <= PS_ADDR0;
                        if (last_out) begin
                            busy <= 1'b0;
                            done <= 1'b1;
                        end else if (col == 4'(POOL_OUT - 1)) begin
                            col <= '0;
                            if (row == 4'(POOL_OUT - 1)) begin
                                row  <= '0;
                                filt <= filt + 4'd1;
                            end else begin
                                row <= row + 4'd1;
                            end
                        end else begin
                            col <= col + 4'd1;
                        end
                    end
                    default: step <= PS_ADDR0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* source/dense_engine.sv */
`timescale 1ns/1ns
`default_nettype none

// Dense layer engine
// Class scores over the pooled features, with a running argmax for the digit

module dense_engine import cnn_pkg::*; (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    output logic                   done,
    output logic [DENSE_W_AW-1:0]  dense_w_addr,
    input  wire pixel_t            dense_w_data,
    output logic [DENSE_B_AW-1:0]  dense_b_addr,
    input  wire acc_t              dense_b_data,
    feature_buf_if.consumer        feat,
    output score_array_t           scores,
    output logic [3:0]             predicted_digit
);

    typedef enum logic [2:0] {
        D_IDLE,
        D_BIAS_ADDR,
        D_BIAS_CAP,
        D_PREFETCH,
        D_MAC,
        D_SCORE
    } dense_state_t;

    dense_state_t        state;
    logic [3:0]          cls;
    logic [BUF_B_AW-1:0] flat;
    acc_t                acc;
    acc_t                best;

    function automatic logic [DENSE_W_AW-1:0] w_addr(logic [3:0] c,
                                                      logic [BUF_B_AW-1:0] idx);
        return DENSE_W_AW'(c * FLAT_LEN + idx);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= D_IDLE;
            done            <= 1'b0;
            predicted_digit <= '0;
            scores          <= '{default: '0};
        end else begin
            done <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (start) begin
                        cls   <= '0;
                        state <= D_BIAS_ADDR;
                    end
                end
                D_BIAS_ADDR: begin
                    dense_b_addr <= cls;
                    state        <= D_BIAS_CAP;
                end
                D_BIAS_CAP: begin
                    acc          <= dense_b_data;
                    flat         <= '0;
                    feat.rd_addr <= '0;
                    dense_w_addr <= w_addr(cls, '0);
                    state        <= D_PREFETCH;
                end
                D_PREFETCH: begin
                    state <= D_MAC;
                end
                D_MAC: begin
                    acc <= acc + acc_t'(feat.rd_data) * acc_t'(dense_w_data);
                    if (flat == BUF_B_AW'(FLAT_LEN - 1)) begin
                        state <= D_SCORE;
                    end else begin
                        flat         <= flat + 1'b1;
                        feat.rd_addr <= flat + 1'b1;
                        dense_w_addr <= w_addr(cls, flat + 1'b1);
                    end
                end
                D_SCORE: begin
                    scores[cls] <= acc;
                    // Ties keep the earlier class
                    if (cls == 4'd0 || acc > best) begin
                        best            <= acc;
                        predicted_digit <= cls;
                    end
                    if (cls == 4'(NUM_CLASSES - 1)) begin
                        done  <= 1'b1;
                        state <= D_IDLE;
                    end else begin
                        cls   <= cls + 4'd1;
                        state <= D_BIAS_ADDR;
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/inference_top.sv */
`timescale 1ns/1ns
`default_nettype none

// Digit classifier top level
// Sequences conv, pool and dense phases over two internal feature buffers

module inference_top import cnn_pkg::*; (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    output logic                   done,
    output logic [IMG_AW-1:0]      img_addr,
    input  wire pixel_t            img_data,
    output logic [CONV_W_AW-1:0]   conv_w_addr,
    input  wire pixel_t            conv_w_data,
    output logic [CONV_B_AW-1:0]   conv_b_addr,
    input  wire acc_t              conv_b_data,
    output logic [DENSE_W_AW-1:0]  dense_w_addr,
    input  wire pixel_t            dense_w_data,
    output logic [DENSE_B_AW-1:0]  dense_b_addr,
    input  wire acc_t              dense_b_data,
    output score_array_t           scores,
    output logic [3:0]             predicted_digit
);

    phase_t phase;
    logic   conv_start;
    logic   conv_done;
    logic   pool_start;
    logic   pool_done;
    logic   dense_start;
    logic   dense_done;

    feature_buf_if #(.AW(BUF_A_AW)) buf_a ();
    feature_buf_if #(.AW(BUF_B_AW)) buf_b ();

    // ========================================================================
    // Phase sequencer
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            phase       <= IDLE;
            conv_start  <= 1'b0;
            pool_start  <= 1'b0;
            dense_start <= 1'b0;
        end else begin
            conv_start  <= 1'b0;
            pool_start  <= 1'b0;
            dense_start <= 1'b0;
            case (phase)
                IDLE: begin
                    if (start) begin
                        phase      <= CONV;
                        conv_start <= 1'b1;
                    end
                end
                CONV: begin
                    if (conv_done) begin
                        phase      <= POOL;
                        pool_start <= 1'b1;
                    end
                end
                POOL: begin
                    if (pool_done) begin
                        phase       <= DENSE;
                        dense_start <= 1'b1;
                    end
                end
                DENSE: begin
                    if (dense_done) begin
                        phase <= FINISH;
                    end
                end
                FINISH: phase <= IDLE;
                default: phase <= IDLE;
            endcase
        end
    end

    // One-cycle pulse, the cycle after the dense engine finishes
    assign done = (phase == FINISH);

    // ========================================================================
    // Buffers and engines
    // ========================================================================
    feature_buffer #(.DEPTH(BUF_A_DEPTH)) buf_a_mem (
        .clk (clk),
        .bus (buf_a.mem)
    );

    feature_buffer #(.DEPTH(BUF_B_DEPTH)) buf_b_mem (
        .clk (clk),
        .bus (buf_b.mem)
    );

    conv_engine conv_i (
        .clk         (clk),
        .rst         (rst),
        .start       (conv_start),
        .done        (conv_done),
        .img_addr    (img_addr),
        .img_data    (img_data),
        .conv_w_addr (conv_w_addr),
        .conv_w_data (conv_w_data),
        .conv_b_addr (conv_b_addr),
        .conv_b_data (conv_b_data),
        .fmap        (buf_a.producer)
    );

    pool_engine pool_i (
        .clk   (clk),
        .rst   (rst),
        .start (pool_start),
        .done  (pool_done),
        .src   (buf_a.consumer),
        .dst   (buf_b.producer)
    );

    dense_engine dense_i (
        .clk             (clk),
        .rst             (rst),
        .start           (dense_start),
        .done            (dense_done),
        .dense_w_addr    (dense_w_addr),
        .dense_w_data    (dense_w_data),
        .dense_b_addr    (dense_b_addr),
        .dense_b_data    (dense_b_data),
        .feat            (buf_b.consumer),
        .scores          (scores),
        .predicted_digit (predicted_digit)
    );

endmodule

`default_nettype wire

/* test/tb_inference.sv */
`timescale 1ns/1ns
`default_nettype none

// Testbench for the digit classifier
// Random memory models, a behavioral conv/pool/dense reference and assertion checks

module tb_inference import cnn_pkg::*; ();

    localparam int RUN_LIMIT = 250000;

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic                  done;
    logic [IMG_AW-1:0]     img_addr;
    pixel_t                img_data;
    logic [CONV_W_AW-1:0]  conv_w_addr;
    pixel_t                conv_w_data;
    logic [CONV_B_AW-1:0]  conv_b_addr;
    acc_t                  conv_b_data;
    logic [DENSE_W_AW-1:0] dense_w_addr;
    pixel_t                dense_w_data;
    logic [DENSE_B_AW-1:0] dense_b_addr;
    acc_t                  dense_b_data;
    score_array_t          scores;
    logic [3:0]            predicted_digit;

    // External memories, one entry per address
    pixel_t img_mem     [2**IMG_AW];
    pixel_t conv_w_mem  [2**CONV_W_AW];
    acc_t   conv_b_mem  [2**CONV_B_AW];
    pixel_t dense_w_mem [2**DENSE_W_AW];
    acc_t   dense_b_mem [2**DENSE_B_AW];

    // Reference model results
    int     ref_act    [BUF_A_DEPTH];
    int     ref_pool   [FLAT_LEN];
    acc_t   ref_scores [NUM_CLASSES];
    int     ref_digit;
    int     base_latency;
    int     last_latency;

    assign img_data     = img_mem[img_addr];
    assign conv_w_data  = conv_w_mem[conv_w_addr];
    assign conv_b_data  = conv_b_mem[conv_b_addr];
    assign dense_w_data = dense_w_mem[dense_w_addr];
    assign dense_b_data = dense_b_mem[dense_b_addr];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    inference_top dut_i (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .done            (done),
        .img_addr        (img_addr),
        .img_data        (img_data),
        .conv_w_addr     (conv_w_addr),
        .conv_w_data     (conv_w_data),
        .conv_b_addr     (conv_b_addr),
        .conv_b_data     (conv_b_data),
        .dense_w_addr    (dense_w_addr),
        .dense_w_data    (dense_w_data),
        .dense_b_addr    (dense_b_addr),
        .dense_b_data    (dense_b_data),
        .scores          (scores),
        .predicted_digit (predicted_digit)
    );

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input longint expected, input longint actual);
        assert (actual == expected) else begin
            $display("FAILED at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    // ========================================================================
    // Memory contents
    // ========================================================================
    task automatic fill_image();
        foreach (img_mem[i]) begin
            img_mem[i] = pixel_t'($urandom);
        end
    endtask

    task automatic fill_weights();
        foreach (conv_w_mem[i]) begin
            conv_w_mem[i] = pixel_t'($urandom);
        end
        // Small conv biases so that not every output clamps
        foreach (conv_b_mem[i]) begin
            conv_b_mem[i] = acc_t'($urandom) >>> 20;
        end
        foreach (dense_w_mem[i]) begin
            dense_w_mem[i] = pixel_t'($urandom);
        end
        foreach (dense_b_mem[i]) begin
            dense_b_mem[i] = acc_t'($urandom) >>> 16;
        end
    endtask

    // Zero weights, so scores equal the biases; classes 3 and 7 share the peak
    task automatic load_tie_case(input bit negative);
        foreach (dense_w_mem[i]) begin
            dense_w_mem[i] = '0;
        end
        for (int i = 0; i < NUM_CLASSES; i++) begin
            dense_b_mem[i] = negative ? -30000 - 100 * i : 1000 * i;
        end
        dense_b_mem[3] = negative ? -500 : 50000;
        dense_b_mem[7] = dense_b_mem[3];
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================
    task automatic compute_reference();
        int sum;
        int q;
        int m;
        int best;
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int r = 0; r < CONV_OUT; r++) begin
                for (int c = 0; c < CONV_OUT; c++) begin
                    sum = conv_b_mem[f];
                    for (int kr = 0; kr < KERNEL; kr++) begin
                        for (int kc = 0; kc < KERNEL; kc++) begin
                            sum += int'(img_mem[(r + kr) * IMG_SIZE + c + kc])
                                   * int'(conv_w_mem[(f * KERNEL + kr) * KERNEL + kc]);
                        end
                    end
                    q = sum >>> QUANT_SHIFT;
                    q = (q < 0) ? 0 : ((q > ACT_MAX) ? ACT_MAX : q);
                    ref_act[(f * CONV_OUT + r) * CONV_OUT + c] = q;
                end
            end
        end
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int r = 0; r < POOL_OUT; r++) begin
                for (int c = 0; c < POOL_OUT; c++) begin
                    m = 0;
                    for (int d = 0; d < 4; d++) begin
                        q = ref_act[(f * CONV_OUT + 2 * r + d / 2) * CONV_OUT + 2 * c + d % 2];
                        m = (q > m) ? q : m;
                    end
                    ref_pool[(f * POOL_OUT + r) * POOL_OUT + c] = m;
                end
            end
        end
        for (int cl = 0; cl < NUM_CLASSES; cl++) begin
            sum = dense_b_mem[cl];
            for (int i = 0; i < FLAT_LEN; i++) begin
                sum += ref_pool[i] * int'(dense_w_mem[cl * FLAT_LEN + i]);
            end
            ref_scores[cl] = sum;
        end
        // First class with the strictly largest score
        ref_digit = 0;
        best      = ref_scores[0];
        for (int cl = 1; cl < NUM_CLASSES; cl++) begin
            if (ref_scores[cl] > best) begin
                best      = ref_scores[cl];
                ref_digit = cl;
            end
        end
    endtask

    // ========================================================================
    // Run control and checks
    // ========================================================================
    task automatic run_inference(input bit poke_busy);
        int cycles;
        cycles = 0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        while (done !== 1'b1) begin
            if (cycles >= RUN_LIMIT) begin
                $display("Timeout: no done pulse within %0d cycles of start", RUN_LIMIT);
                abort_run();
            end
            @(posedge clk);
            // Extra starts land in the conv, pool and dense phases
            start <= poke_busy && (cycles == 64 || cycles == 150000 || cycles == 170000);
            @(negedge clk);
            cycles++;
        end
        last_latency = cycles;
        @(negedge clk);
        check_value("done", 0, done);
    endtask

    task automatic check_results();
        for (int i = 0; i < NUM_CLASSES; i++) begin
            check_value($sformatf("scores[%0d]", i), ref_scores[i], scores[i]);
        end
        check_value("predicted_digit", ref_digit, predicted_digit);
    endtask

    task automatic expect_quiet(input int window);
        for (int i = 0; i < window; i++) begin
            @(negedge clk);
            check_value("done", 0, done);
        end
    endtask

    initial begin
        void'($urandom(32'h3f436e35));
        rst   = 1'b1;
        start = 1'b0;
        fill_image();
        fill_weights();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("done", 0, done);
        check_value("predicted_digit", 0, predicted_digit);
        for (int i = 0; i < NUM_CLASSES; i++) begin
            check_value($sformatf("scores[%0d]", i), 0, scores[i]);
        end

        // All scores negative, class 0 seeds the running best
        load_tie_case(1'b1);
        compute_reference();
        run_inference(1'b0);
        base_latency = last_latency;
        check_results();
        check_value("predicted_digit", 3, predicted_digit);

        // Tied peak, lower index wins
        load_tie_case(1'b0);
        compute_reference();
        run_inference(1'b0);
        check_results();
        check_value("predicted_digit", 3, predicted_digit);

        // Random weights
        fill_weights();
        compute_reference();
        run_inference(1'b0);
        check_results();

        // New image with start pulses while busy
        fill_image();
        fill_weights();
        compute_reference();
        run_inference(1'b1);
        check_value("run latency", base_latency, last_latency);
        check_results();
        // Longer than a whole run, so a stored start would show up
        expect_quiet(base_latency + 100);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
source/cnn_pkg.sv
source/feature_buf_if.sv
source/feature_buffer.sv
source/conv_engine.sv
source/pool_engine.sv
source/dense_engine.sv
source/inference_top.sv
test/tb_inference.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the inference testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_inference \
    -o sim_inference > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/sim_inference > "$SIM_LOG" 2>&1
sim_status=$?

if grep -q "Something failed" "$SIM_LOG"; then
    echo "Simulation reported an error, see $SIM_LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status, see $SIM_LOG"
    exit 1
fi

echo "Simulation passed, log in $SIM_LOG"
exit 0
